/* design/ahbLed_macros.svh */
`ifndef AHBLED_MACROS_SVH
`define AHBLED_MACROS_SVH

// --------------------------------------
// Address map, upper nibble of HADDR
// --------------------------------------
`define AHBLED_RAM_REGION 4'h2
`define AHBLED_LED_REGION 4'h4

// RAM word-address width, 2**AW words
`define AHBLED_RAM_AW 10

// --------------------------------------
// LED slave register offsets
// --------------------------------------
`define AHBLED_LED_MODE_OFF  8'h00
`define AHBLED_LED_SPEED_OFF 8'h04

`endif

/* design/ahbLedPkg.sv */
package ahbLedPkg;

        // --------------------------------------
        // Bus fields
        // --------------------------------------
        typedef logic [31:0] haddr_t;
        typedef logic [31:0] hdata_t;
        typedef logic [1:0]  htrans_t;  // IDLE, BUSY, NONSEQ, SEQ
        typedef logic [2:0]  hsize_t;

        // LED slave values
        typedef logic [7:0]  led_t;
        typedef logic [7:0]  ledMode_t;
        typedef logic [31:0] ledSpeed_t; // Step period in cycles

        // Default slave, two-cycle ERROR response
        typedef enum logic [1:0] {
                ERR_IDLE,
                ERR_FIRST,
                ERR_SECOND
        } errState_e;

endpackage

/* design/ahbInterconnect.sv */
`include "ahbLed_macros.svh"

module ahbInterconnect (
        input  logic               clk,
        input  logic               RSTn,
        input  ahbLedPkg::haddr_t  HADDR,
        input  ahbLedPkg::htrans_t HTRANS,
        input  ahbLedPkg::hdata_t  ramRdata,
        input  ahbLedPkg::hdata_t  ledRdata,
        output logic               selRam,
        output logic               selLed,
        output ahbLedPkg::hdata_t  HRDATA,
        output logic               HREADY,
        output logic               HRESP
);
        import ahbLedPkg::*;

        logic      transActive;
        logic      unmapped;
        logic      ownRam;
        logic      ownLed;
        errState_e errState;
        errState_e errNext;

        // --------------------------------------
        // Address decode
        // --------------------------------------
        assign selRam = (HADDR[31:28] == `AHBLED_RAM_REGION);
        assign selLed = (HADDR[31:28] == `AHBLED_LED_REGION);
        assign unmapped = !selRam && !selLed;

        // NONSEQ or SEQ while the bus is ready
        assign transActive = HTRANS[1] && HREADY;

        // Data-phase owner held across wait states
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        ownRam <= 1'b0;
                        ownLed <= 1'b0;
                end else if (HREADY) begin
                        ownRam <= transActive && selRam;
                        ownLed <= transActive && selLed;
                end
        end

        always_comb begin
                if (ownRam) begin
                        HRDATA = ramRdata;
                end else if (ownLed) begin
                        HRDATA = ledRdata;
                end else begin
                        HRDATA = '0;       // Idle or error data phase
                end
        end

        // --------------------------------------
        // Default slave
        // --------------------------------------
        always_comb begin
                errNext = ERR_IDLE;
                case (errState)
                        ERR_FIRST:  errNext = ERR_SECOND;
                        // Back-to-back errors go straight to a new first cycle
                        default:    errNext = (transActive && unmapped) ? ERR_FIRST : ERR_IDLE;
                endcase
        end

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        errState <= ERR_IDLE;
                end else begin
                        errState <= errNext;
                end
        end

        assign HREADY = (errState != ERR_FIRST);  // Only wait state on the bus
        assign HRESP  = (errState != ERR_IDLE);

        // An error data phase stalls the bus and belongs to no slave
        assert property (@(posedge clk) disable iff (!RSTn)
                (errState == ERR_FIRST) |-> !HREADY && !ownRam && !ownLed);

        // Regions are exclusive, so is the data-phase owner
        assert property (@(posedge clk) disable iff (!RSTn)
                !(selRam && selLed) && !(ownRam && ownLed));

endmodule

/* design/ahbBlockRam.sv */
`include "ahbLed_macros.svh"

module ahbBlockRam (
        input  logic               clk,
        input  logic               RSTn,
        input  logic               HSEL,
        input  ahbLedPkg::haddr_t  HADDR,
        input  ahbLedPkg::htrans_t HTRANS,
        input  ahbLedPkg::hsize_t  HSIZE,
        input  logic               HWRITE,
        input  ahbLedPkg::hdata_t  HWDATA,
        input  logic               HREADY,
        output ahbLedPkg::hdata_t  HRDATA
);
        import ahbLedPkg::*;

        localparam int AW = `AHBLED_RAM_AW;

        logic          transActive;
        logic          rdEn;
        logic          wrEn;
        logic          fwdHit;
        logic          wrPending;
        logic [3:0]    laneMask;
        logic [3:0]    wrLanes;
        logic [AW-1:0] rdAddr;
        logic [AW-1:0] wrAddr;
        hdata_t        rdData;
        hdata_t        mem [0:(1 << AW) - 1];

        assign transActive = HSEL && HTRANS[1] && HREADY;
        assign rdAddr      = HADDR[AW+1:2];
        assign rdEn        = transActive && !HWRITE;

        // --------------------------------------
        // Byte lanes from size and low address
        // --------------------------------------
        always_comb begin
                case (HSIZE)
                        3'b000:  laneMask = 4'b0001 << HADDR[1:0];
                        3'b001:  laneMask = HADDR[1] ? 4'b1100 : 4'b0011;
                        default: laneMask = 4'b1111;
                endcase
        end

        // Write address phase
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        wrPending <= 1'b0;
                end else if (HREADY) begin
                        wrPending <= transActive && HWRITE;
                end
        end

        always_ff @(posedge clk) begin
                if (transActive && HWRITE) begin
                        wrAddr  <= rdAddr;
                        wrLanes <= laneMask;
                end
        end

        // --------------------------------------
        // Array and read port
        // --------------------------------------
        assign wrEn   = wrPending && HREADY;       // Write data phase
        assign fwdHit = wrEn && (wrAddr == rdAddr);

        always_ff @(posedge clk) begin
                if (wrEn) begin
                        for (int i = 0; i < 4; i++) begin
                                if (wrLanes[i]) begin
                                        mem[wrAddr][8*i +: 8] <= HWDATA[8*i +: 8];
                                end
                        end
                end
        end

        // Read of the word written this cycle takes the new bytes
        always_ff @(posedge clk) begin
                if (rdEn) begin
                        for (int i = 0; i < 4; i++) begin
                                if (fwdHit && wrLanes[i]) begin
                                        rdData[8*i +: 8] <= HWDATA[8*i +: 8];
                                end else begin
                                        rdData[8*i +: 8] <= mem[rdAddr][8*i +: 8];
                                end
                        end
                end
        end

        assign HRDATA = rdData;

        // At most a word, naturally aligned
        assert property (@(posedge clk) disable iff (!RSTn)
                transActive |-> (HSIZE <= 3'd2)
                        && (HSIZE != 3'd1 || !HADDR[0])
                        && (HSIZE != 3'd2 || HADDR[1:0] == 2'b00));

endmodule

/* design/ahbWaterLight.sv */
`include "ahbLed_macros.svh"

module ahbWaterLight (
        input  logic               clk,
        input  logic               RSTn,
        input  logic               HSEL,
        input  ahbLedPkg::haddr_t  HADDR,
        input  ahbLedPkg::htrans_t HTRANS,
        input  logic               HWRITE,
        input  ahbLedPkg::hdata_t  HWDATA,
        input  logic               HREADY,
        output ahbLedPkg::hdata_t  HRDATA,
        output ahbLedPkg::led_t    LED
);
        import ahbLedPkg::*;

        logic      transActive;
        logic      wrPending;
        logic      modeWr;
        logic      speedWr;
        logic [7:0] regOff;
        ledMode_t  mode;
        ledSpeed_t speed;
        ledSpeed_t stepCnt;
        led_t      pattern;

        // Pattern loaded by a mode write
        function automatic led_t startPattern(input ledMode_t m);
                case (m)
                        8'd1:    return 8'h01;
                        8'd2:    return 8'h80;
                        8'd3:    return 8'hFF;
                        default: return 8'h00;
                endcase
        endfunction

        // One step of the current mode
        function automatic led_t nextPattern(input ledMode_t m, input led_t p);
                case (m)
                        8'd1:    return {p[6:0], p[7]};
                        8'd2:    return {p[0], p[7:1]};
                        8'd3:    return ~p;
                        default: return 8'h00;
                endcase
        endfunction

        // --------------------------------------
        // Bus side
        // --------------------------------------
        assign transActive = HSEL && HTRANS[1] && HREADY;

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        wrPending <= 1'b0;
                        regOff    <= 8'h00;
                end else if (HREADY) begin
                        wrPending <= transActive && HWRITE;
                        if (transActive) begin
                                regOff <= HADDR[7:0];
                        end
                end
        end

        assign modeWr  = wrPending && HREADY && (regOff == `AHBLED_LED_MODE_OFF);
        assign speedWr = wrPending && HREADY && (regOff == `AHBLED_LED_SPEED_OFF);

        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        mode  <= '0;
                        speed <= '0;
                end else begin
                        if (modeWr) begin
                                mode <= HWDATA[7:0];
                        end
                        if (speedWr) begin
                                speed <= HWDATA;
                        end
                end
        end

        always_comb begin
                case (regOff)
                        `AHBLED_LED_MODE_OFF:  HRDATA = {24'h0, mode};
                        `AHBLED_LED_SPEED_OFF: HRDATA = speed;
                        default:               HRDATA = '0;
                endcase
        end

        // --------------------------------------
        // Pattern generator
        // --------------------------------------
        always_ff @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        stepCnt <= '0;
                        pattern <= '0;
                end else if (modeWr) begin
                        stepCnt <= '0;
                        pattern <= startPattern(HWDATA[7:0]);
                end else if (speedWr) begin
                        stepCnt <= '0;             // Restart period, no step
                end else if (stepCnt == speed) begin
                        stepCnt <= '0;
                        pattern <= nextPattern(mode, pattern);
                end else begin
                        stepCnt <= stepCnt + 32'd1;
                end
        end

        assign LED = pattern;

        // Speed writes restart the count, so it never runs past the period
        assert property (@(posedge clk) disable iff (!RSTn) stepCnt <= speed);

endmodule

/* design/ahbLedSys.sv */
module ahbLedSys (
        input  logic               clk,
        input  logic               RSTn,
        input  ahbLedPkg::haddr_t  HADDR,
        input  ahbLedPkg::htrans_t HTRANS,
        input  ahbLedPkg::hsize_t  HSIZE,
        input  logic               HWRITE,
        input  ahbLedPkg::hdata_t  HWDATA,
        output ahbLedPkg::hdata_t  HRDATA,
        output logic               HREADY,
        output logic               HRESP,
        output ahbLedPkg::led_t    LED
);
        import ahbLedPkg::*;

        logic   selRam;
        logic   selLed;
        hdata_t ramRdata;
        hdata_t ledRdata;

        // --------------------------------------
        // Decode, response and read-data mux
        // --------------------------------------
        ahbInterconnect uInterconnect (
                .clk      (clk),
                .RSTn     (RSTn),
                .HADDR    (HADDR),
                .HTRANS   (HTRANS),
                .ramRdata (ramRdata),
                .ledRdata (ledRdata),
                .selRam   (selRam),
                .selLed   (selLed),
                .HRDATA   (HRDATA),
                .HREADY   (HREADY),
                .HRESP    (HRESP)
        );

        ahbBlockRam uRam (
                .clk    (clk),
                .RSTn   (RSTn),
                .HSEL   (selRam),
                .HADDR  (HADDR),
                .HTRANS (HTRANS),
                .HSIZE  (HSIZE),
                .HWRITE (HWRITE),
                .HWDATA (HWDATA),
                .HREADY (HREADY),
                .HRDATA (ramRdata)
        );

        ahbWaterLight uWaterLight (
                .clk    (clk),
                .RSTn   (RSTn),
                .HSEL   (selLed),
                .HADDR  (HADDR),
                .HTRANS (HTRANS),
                .HWRITE (HWRITE),
                .HWDATA (HWDATA),
                .HREADY (HREADY),
                .HRDATA (ledRdata),
                .LED    (LED)      // Registered pattern
        );

endmodule

/* tests/clkGen.sv */
module clkGen #(
        parameter int PERIOD_NS = 4
) (
        output logic clk
);
        timeunit 1ns;
        timeprecision 100ps;

        // Free running, even duty cycle
        initial begin
                clk = 1'b0;
                forever begin
                        #(PERIOD_NS / 2) clk = ~clk;
                end
        end

endmodule

/* tests/tbAhbLedSys.sv */
`include "ahbLed_macros.svh"

module tbAhbLedSys;
        timeunit 1ns;
        timeprecision 100ps;
        import ahbLedPkg::*;

        localparam int CLK_NS  = 4;
        localparam int NWORDS  = 1 << `AHBLED_RAM_AW;
        localparam int NRAND   = 300;
        localparam int NFWD    = 3;             // Write/read pairs per size
        localparam int NREG    = 4;
        localparam int NROUNDS = 12;
        localparam int LED_OBS = 64;
        localparam int NERR    = 20;
        localparam int NXFERS  = NWORDS + NRAND + 6 * NFWD + 4 * NREG + 2 * NROUNDS + 2 * NERR + 1;
        localparam int LIMIT_NS = (16 + 4 * NXFERS + NROUNDS * LED_OBS + 100) * CLK_NS;

        typedef enum {DP_IDLE, DP_RAMRD, DP_RAMWR, DP_LEDRD, DP_LEDWR, DP_ERR} dpKind_e;

        logic    clk;
        logic    RSTn;
        haddr_t  HADDR;
        htrans_t HTRANS;
        hsize_t  HSIZE;
        logic    HWRITE;
        hdata_t  HWDATA;
        hdata_t  HRDATA;
        logic    HREADY;
        logic    HRESP;
        led_t    LED;

        // Reference model
        hdata_t    ramModel [0:NWORDS-1];
        ledMode_t  regMode;          // Register view in issue order
        ledSpeed_t regSpeed;
        ledMode_t  stepMode;         // Cycle view of the LED generator
        ledSpeed_t stepSpeed;
        ledSpeed_t stepCount;
        led_t      stepLeds;
        logic      wrModeNow = 1'b0;
        logic      wrSpeedNow = 1'b0;
        hdata_t    wrDataNow = '0;

        // Transfer currently in its data phase
        dpKind_e    dpKind = DP_IDLE;
        hdata_t     dpData = '0;     // Write data or expected read data
        logic [7:0] dpOff = 8'h00;

        clkGen #(.PERIOD_NS(CLK_NS)) uClk (.clk(clk));

        ahbLedSys uut (
                .clk    (clk),
                .RSTn   (RSTn),
                .HADDR  (HADDR),
                .HTRANS (HTRANS),
                .HSIZE  (HSIZE),
                .HWRITE (HWRITE),
                .HWDATA (HWDATA),
                .HRDATA (HRDATA),
                .HREADY (HREADY),
                .HRESP  (HRESP),
                .LED    (LED)
        );

        // --------------------------------------
        // Model helpers
        // --------------------------------------
        function automatic led_t firstLeds(input ledMode_t m);
                if (m == 8'd1) return 8'h01;
                if (m == 8'd2) return 8'h80;
                if (m == 8'd3) return 8'hFF;
                return 8'h00;
        endfunction

        function automatic led_t advanceLeds(input ledMode_t m, input led_t p);
                if (m == 8'd1) return (p << 1) | (p >> 7);
                if (m == 8'd2) return (p >> 1) | (p << 7);
                if (m == 8'd3) return p ^ 8'hFF;
                return 8'h00;
        endfunction

        // Byte lanes of a narrow transfer
        function automatic logic [3:0] laneBits(input haddr_t a, input hsize_t s);
                if (s == 3'd2) return 4'hF;
                if (s == 3'd1) return a[1] ? 4'hC : 4'h3;
                return 4'h1 << a[1:0];
        endfunction

        function automatic haddr_t ramAddr(input int w, input logic [1:0] off);
                haddr_t a;
                a = '0;
                a[31:28] = `AHBLED_RAM_REGION;
                a[`AHBLED_RAM_AW+1:2] = w[`AHBLED_RAM_AW-1:0];
                a[1:0] = off;
                return a;
        endfunction

        function automatic haddr_t ledAddr(input logic [7:0] off);
                return {`AHBLED_LED_REGION, 20'h0, off};
        endfunction

        // Every word gets a distinct value
        function automatic hdata_t fillWord(input int w);
                return {w[15:0] ^ 16'hA5C3, ~w[15:0]};
        endfunction

        always @(posedge clk or negedge RSTn) begin
                if (!RSTn) begin
                        stepMode  <= '0;
                        stepSpeed <= '0;
                        stepCount <= '0;
                        stepLeds  <= '0;
                end else if (wrModeNow) begin
                        stepMode  <= wrDataNow[7:0];
                        stepLeds  <= firstLeds(wrDataNow[7:0]);
                        stepCount <= '0;
                end else if (wrSpeedNow) begin
                        stepSpeed <= wrDataNow;
                        stepCount <= '0;
                end else if (stepCount == stepSpeed) begin
                        stepCount <= '0;
                        stepLeds  <= advanceLeds(stepMode, stepLeds);
                end else begin
                        stepCount <= stepCount + 32'd1;
                end
        end

        // --------------------------------------
        // Checks
        // --------------------------------------
        task automatic abortRun(input string why);
                $display("%s", why);
                $display(">>> FAIL");
                $fatal(1, "Run stopped at the first error");
        endtask

        task automatic checkData(input string name, input hdata_t exp, input hdata_t act);
                if (act !== exp) begin
                        abortRun($sformatf("ERROR %s expected %h actual %h", name, exp, act));
                end
        endtask

        task automatic checkLed(input led_t exp, input led_t act);
                if (act !== exp) begin
                        abortRun($sformatf("ERROR LED expected %h actual %h", exp, act));
                end
        endtask

        task automatic checkResp(input logic expReady, input logic expResp,
                                 input logic actReady, input logic actResp);
                if (actReady !== expReady || actResp !== expResp) begin
                        abortRun($sformatf("ERROR HREADY/HRESP expected %h/%h actual %h/%h",
                                           expReady, expResp, actReady, actResp));
                end
        endtask

        // New address phase plus the data phase of the previous transfer
        task automatic busCycle(input logic active, input haddr_t addr, input hsize_t size,
                                input logic write, input hdata_t wdata);
                dpKind_e                  kind;
                hdata_t                   data;
                logic [3:0]               lanes;
                logic [`AHBLED_RAM_AW-1:0] wa;
                kind = DP_IDLE;
                data = wdata;
                lanes = laneBits(addr, size);
                wa = addr[`AHBLED_RAM_AW+1:2];
                if (active && addr[31:28] == `AHBLED_RAM_REGION) begin
                        kind = write ? DP_RAMWR : DP_RAMRD;
                        for (int i = 0; i < 4; i++) begin
                                if (write && lanes[i]) begin
                                        ramModel[wa][8*i +: 8] = wdata[8*i +: 8];
                                end
                        end
                        if (!write) data = ramModel[wa];
                end else if (active && addr[31:28] == `AHBLED_LED_REGION) begin
                        kind = write ? DP_LEDWR : DP_LEDRD;
                        if (write && addr[7:0] == `AHBLED_LED_MODE_OFF) regMode = wdata[7:0];
                        if (write && addr[7:0] == `AHBLED_LED_SPEED_OFF) regSpeed = wdata;
                        if (!write) begin
                                data = '0;
                                if (addr[7:0] == `AHBLED_LED_MODE_OFF) data = {24'h0, regMode};
                                if (addr[7:0] == `AHBLED_LED_SPEED_OFF) data = regSpeed;
                        end
                end else if (active) begin
                        kind = DP_ERR;
                end
                HADDR  = addr;
                HTRANS = active ? 2'b10 : 2'b00;     // NONSEQ or IDLE
                HSIZE  = size;
                HWRITE = write;
                HWDATA = (dpKind == DP_RAMWR || dpKind == DP_LEDWR) ? dpData : '0;
                wrModeNow  = (dpKind == DP_LEDWR) && (dpOff == `AHBLED_LED_MODE_OFF);
                wrSpeedNow = (dpKind == DP_LEDWR) && (dpOff == `AHBLED_LED_SPEED_OFF);
                wrDataNow  = dpData;
                @(negedge clk);
                checkLed(stepLeds, LED);
                if (dpKind == DP_ERR) begin
                        checkResp(1'b0, 1'b1, HREADY, HRESP);   // Address phase held
                        @(negedge clk);
                        checkLed(stepLeds, LED);
                        checkResp(1'b1, 1'b1, HREADY, HRESP);
                end else begin
                        checkResp(1'b1, 1'b0, HREADY, HRESP);
                        if (dpKind == DP_RAMRD || dpKind == DP_LEDRD) begin
                                checkData("HRDATA", dpData, HRDATA);
                        end
                end
                @(posedge clk);
                #1;
                dpKind = kind;
                dpData = data;
                dpOff  = addr[7:0];
        endtask

        // --------------------------------------
        // Stimulus
        // --------------------------------------
        initial begin
                hsize_t     s;
                logic [1:0] off;
                logic [3:0] nib;
                int         w;
                void'($urandom(91707));
                RSTn = 1'b0;
                HADDR = '0;
                HTRANS = 2'b00;
                HSIZE = 3'd0;
                HWRITE = 1'b0;
                HWDATA = '0;
                regMode = '0;
                regSpeed = '0;
                repeat (16) @(posedge clk);
                #1;
                RSTn = 1'b1;
                @(negedge clk);
                checkLed(8'h00, LED);
                checkResp(1'b1, 1'b0, HREADY, HRESP);
                checkData("HRDATA", '0, HRDATA);
                @(posedge clk);
                #1;

                for (int n = 0; n < NWORDS; n++) begin
                        busCycle(1'b1, ramAddr(n, 2'b00), 3'd2, 1'b1, fillWord(n));
                end
                for (int n = 0; n < NRAND; n++) begin
                        s = hsize_t'($urandom_range(2, 0));
                        off = 2'($urandom_range(3, 0));
                        if (s == 3'd1) off[0] = 1'b0;
                        if (s == 3'd2) off = 2'b00;
                        w = int'($urandom_range(NWORDS - 1, 0));
                        busCycle(1'b1, ramAddr(w, off), s, 1'($urandom_range(1, 0)), $urandom());
                end

                // Read straight after a write to the same word
                for (int n = 0; n < 3 * NFWD; n++) begin
                        s = hsize_t'(n % 3);
                        off = (s == 3'd0) ? 2'($urandom_range(3, 0)) : 2'b00;
                        if (s == 3'd1) off[1] = 1'($urandom_range(1, 0));
                        w = int'($urandom_range(NWORDS - 1, 0));
                        busCycle(1'b1, ramAddr(w, off), s, 1'b1, $urandom());
                        busCycle(1'b1, ramAddr(w, 2'b00), 3'd2, 1'b0, '0);
                end

                for (int n = 0; n < NREG; n++) begin
                        busCycle(1'b1, ledAddr(`AHBLED_LED_MODE_OFF), 3'd2, 1'b1, $urandom());
                        busCycle(1'b1, ledAddr(`AHBLED_LED_MODE_OFF), 3'd2, 1'b0, '0);
                        busCycle(1'b1, ledAddr(`AHBLED_LED_SPEED_OFF), 3'd2, 1'b1, $urandom());
                        busCycle(1'b1, ledAddr(`AHBLED_LED_SPEED_OFF), 3'd2, 1'b0, '0);
                end

                // First rounds walk through every mode
                for (int n = 0; n < NROUNDS; n++) begin
                        busCycle(1'b1, ledAddr(`AHBLED_LED_SPEED_OFF), 3'd2, 1'b1,
                                 $urandom_range(7, 0));
                        busCycle(1'b1, ledAddr(`AHBLED_LED_MODE_OFF), 3'd2, 1'b1,
                                 (n < 5) ? n : $urandom_range(4, 0));
                        repeat (LED_OBS) busCycle(1'b0, '0, 3'd2, 1'b0, '0);
                end

                for (int n = 0; n < NERR; n++) begin
                        do begin
                                nib = 4'($urandom_range(15, 0));
                        end while (nib == `AHBLED_RAM_REGION || nib == `AHBLED_LED_REGION);
                        busCycle(1'b1, {nib, 28'($urandom())}, 3'd2, 1'($urandom_range(1, 0)),
                                 $urandom());
                        w = int'($urandom_range(NWORDS - 1, 0));
                        busCycle(1'b1, ramAddr(w, 2'b00), 3'd2, 1'b0, '0);
                end
                busCycle(1'b0, '0, 3'd2, 1'b0, '0);   // Last data phase

                $display(">>> PASS");
                $finish;
        end

        initial begin
                #(LIMIT_NS);
                abortRun("Timeout, the bus sequence did not complete in the expected time");
        end

endmodule

/* tb.f */
+incdir+design
design/ahbLedPkg.sv
design/ahbInterconnect.sv
design/ahbBlockRam.sv
design/ahbWaterLight.sv
design/ahbLedSys.sv
tests/clkGen.sv
tests/tbAhbLedSys.sv

/* run.sh */
#!/bin/sh
# Compile and run the AHB LED system testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
        -f tb.f --top-module tbAhbLedSys -Mdir obj_dir
if [ $? -ne 0 ]; then
        echo "Verilator compile failed"
        exit 1
fi

./obj_dir/VtbAhbLedSys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
        echo "Simulation exited with status $status"
        exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
        exit 0
fi
echo "Pass line not found in $LOG"
exit 1
